// File: common/shiftPkg.sv
`default_nettype none

`include "shift_config.svh"

package shiftPkg;

    // instruction word is fixed at 32 bits whatever the operand width
    localparam int InstrWidth = 32;

    // bit 1 picks right, bit 0 picks arithmetic
    typedef enum logic [1:0] {
        opSll = 2'b00,  // logical left
        opSrl = 2'b10,  // logical right
        opSra = 2'b11,  // arithmetic right, sign fill
        opSla = 2'b01   // arithmetic left, sign bit held
    } shiftOp_e;

    // register form, amount comes from opB
    typedef struct packed {
        logic                   immSel;
        shiftOp_e               op;
        logic [InstrWidth-4:0]  unused;
    } shiftRegView_s;

    // immediate form, amount comes from shamtImm
    typedef struct packed {
        logic                                   immSel;
        shiftOp_e                               op;
        logic [`SHAMT_BITS-1:0]                 shamtImm;
        logic [InstrWidth-4-`SHAMT_BITS:0]      unused;
    } shiftImmView_s;

    // one instruction word, two decodings
    typedef union packed {
        shiftRegView_s  regView;
        shiftImmView_s  immView;
    } shiftInstr_u;

    // decode to execute
    typedef struct packed {
        logic                       valid;
        shiftOp_e                   op;
        logic [`SHAMT_BITS-1:0]     amount;
        logic [`SHIFT_WIDTH-1:0]    operand;
    } shiftCmd_s;

    // execute to result, operand kept for the overflow check
    typedef struct packed {
        logic                       valid;
        shiftOp_e                   op;
        logic [`SHAMT_BITS-1:0]     amount;
        logic [`SHIFT_WIDTH-1:0]    operand;
        logic [`SHIFT_WIDTH-1:0]    shifted;
    } shiftRes_s;

    // top level output
    typedef struct packed {
        logic                       valid;
        logic [`SHIFT_WIDTH-1:0]    result;
        logic                       zero;
        logic                       overflow;
    } shiftOut_s;

endpackage

`default_nettype wire

// File: common/shift_config.svh
`ifndef SHIFT_CONFIG_SVH
`define SHIFT_CONFIG_SVH

// sizes shared by the shift unit and its testbench

// operand and result width in bits
// 16, 32 and 64 are all fine
`define SHIFT_WIDTH 32

// bits in a shift amount
// always log2 of SHIFT_WIDTH, so change both together
// only the low bits are kept, which gives the modulo-width amount
`define SHAMT_BITS 5

// cycles from inValid to out.valid
// decode, execute and result stages, one register each
// used by the testbench and the bound properties only
`define SHIFT_LATENCY 3

`endif

// File: logic/shiftUnitTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

// three-stage shift unit
// decode, barrel shift, flags
// fixed latency, one item per cycle, no back-pressure
module shiftUnitTop (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inValid,
    input  shiftPkg::shiftInstr_u       instr,
    input  logic [`SHIFT_WIDTH-1:0]     opA,
    input  logic [`SHIFT_WIDTH-1:0]     opB,
    output shiftPkg::shiftOut_s         out
);

    // decode to execute
    shiftPkg::shiftCmd_s cmd;
    // execute to result
    shiftPkg::shiftRes_s res;

    shiftDecode u_shiftDecode (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .instr   (instr),
        .opA     (opA),
        .opB     (opB),
        .cmd     (cmd)
    );

    barrelShifter u_barrelShifter (
        .clk   (clk),
        .arstN (arstN),
        .cmd   (cmd),
        .res   (res)
    );

    // flags and output register
    shiftResult u_shiftResult (
        .clk   (clk),
        .arstN (arstN),
        .res   (res),
        .out   (out)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the shift unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module shiftUnitTb -o shiftUnitSim

# keep running past assertion errors so the summary is printed
./obj_dir/shiftUnitSim +verilator+error+limit+100 | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: shiftUnit/barrelShifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

// execute stage
// log-depth barrel shifter, one level per amount bit
// level k shifts by 2**k when amount[k] is set
module barrelShifter (
    input  logic                    clk,
    input  logic                    arstN,
    input  shiftPkg::shiftCmd_s     cmd,
    output shiftPkg::shiftRes_s     res
);

    localparam int W = `SHIFT_WIDTH;
    localparam int Levels = `SHAMT_BITS;

    // stage[0] is the input, stage[Levels] the shifted value
    logic [Levels:0][W-1:0] stage;

    assign stage[0] = cmd.operand;

    for (genvar k = 0; k < Levels; k++) begin : gLevel
        // fixed step of this level
        localparam int Step = 1 << k;

        // value if this level shifts
        logic [W-1:0] moved;

        always_comb begin
            case (cmd.op)
                // zero fill from the right
                shiftPkg::opSll: moved = stage[k] << Step;
                // zero fill from the left
                shiftPkg::opSrl: moved = stage[k] >> Step;
                // sign fill, stage[k][W-1] is still the original sign
                shiftPkg::opSra: moved = $signed(stage[k]) >>> Step;
                // sign bit stays put, only the magnitude bits move
                shiftPkg::opSla: moved = {stage[k][W-1], stage[k][W-2:0] << Step};
                default:         moved = stage[k];
            endcase
        end

        // bypass the level when its amount bit is clear
        assign stage[k+1] = cmd.amount[k] ? moved : stage[k];
    end

    // strobe register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= cmd.valid;
        end
    end

    // result register, loaded with the strobe
    // op, amount and the unshifted operand ride along
    // so the result stage can judge overflow
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            res.op      <= shiftPkg::opSll;
            res.amount  <= '0;
            res.operand <= '0;
            res.shifted <= '0;
        end else if (cmd.valid) begin
            res.op      <= cmd.op;
            res.amount  <= cmd.amount;
            res.operand <= cmd.operand;
            res.shifted <= stage[Levels];
        end
    end

endmodule

`default_nettype wire

// File: shiftUnit/shiftDecode.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

// first stage of the shift pipeline
// picks the amount from the right view of the instruction word
// and registers everything execute needs
module shiftDecode (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inValid,
    input  shiftPkg::shiftInstr_u       instr,
    input  logic [`SHIFT_WIDTH-1:0]     opA,
    input  logic [`SHIFT_WIDTH-1:0]     opB,
    output shiftPkg::shiftCmd_s         cmd
);

    // amount before the register
    logic [`SHAMT_BITS-1:0] amountSel;
    // op field sits at the same place in both views
    shiftPkg::shiftOp_e     opSel;
    logic                   useImm;

    // immSel is common to both views, read it through regView
    assign useImm = instr.regView.immSel;
    assign opSel  = instr.regView.op;

    // immediate form takes the field inside the word
    // register form takes the low bits of opB
    // dropping the upper opB bits gives the modulo-width amount
    always_comb begin
        if (useImm) begin
            amountSel = instr.immView.shamtImm;
        end else begin
            amountSel = opB[`SHAMT_BITS-1:0];
        end
    end

    // strobe goes through every cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= inValid;
        end
    end

    // payload only moves with a strobe
    // cleared on reset as well, so nothing stale follows reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmd.op      <= shiftPkg::opSll;
            cmd.amount  <= '0;
            cmd.operand <= '0;
        end else if (inValid) begin
            cmd.op      <= opSel;
            cmd.amount  <= amountSel;
            // opA is the value being shifted
            cmd.operand <= opA;
        end
    end

endmodule

`default_nettype wire

// File: shiftUnit/shiftResult.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

// result stage
// forms the flags and registers the unit's output
module shiftResult (
    input  logic                    clk,
    input  logic                    arstN,
    input  shiftPkg::shiftRes_s     res,
    output shiftPkg::shiftOut_s     out
);

    localparam int W = `SHIFT_WIDTH;

    // magnitude bits that fall off the top on an arithmetic left
    logic [W-2:0] lostMask;
    // magnitude bits that disagree with the sign
    logic [W-2:0] signDiff;
    logic         zeroNext;
    logic         overflowNext;

    // top 'amount' bits of the magnitude field, W-2 downwards
    assign lostMask = ~({(W-1){1'b1}} >> res.amount);
    assign signDiff = res.operand[W-2:0] ^ {(W-1){res.operand[W-1]}};

    // no bit set in the shifted value
    assign zeroNext = ~|res.shifted;

    // a lost bit unlike the sign means the signed value changed
    // other ops never flag overflow
    assign overflowNext = (res.op == shiftPkg::opSla) && |(signDiff & lostMask);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= res.valid;
        end
    end

    // output payload, held between strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out.result   <= '0;
            out.zero     <= 1'b0;
            out.overflow <= 1'b0;
        end else if (res.valid) begin
            out.result   <= res.shifted;
            out.zero     <= zeroNext;
            out.overflow <= overflowNext;
        end
    end

endmodule

`default_nettype wire

// File: tests/shiftUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

module shiftUnitTb;

    localparam int W = `SHIFT_WIDTH;
    localparam int Sb = `SHAMT_BITS;
    localparam int Latency = `SHIFT_LATENCY;
    localparam int ClkPeriod = 10;
    localparam int ResetCycles = 4;
    localparam int NumTests = 6;
    localparam int RandomItems = 200;
    // logical 16, sra 12, sla 12, union 8, random, reset 10
    localparam int TotalItems = 16 + 12 + 12 + 8 + RandomItems + 10;
    // one cycle per item, plus drain and reset gaps of every test
    localparam int WatchdogCycles = TotalItems + Latency + 20
                                    + NumTests * (Latency + 8) + 2 * ResetCycles;

    logic                  clk = 1'b0;
    logic                  arstN;
    logic                  inValid;
    shiftPkg::shiftInstr_u instr;
    logic [W-1:0]          opA;
    logic [W-1:0]          opB;
    shiftPkg::shiftOut_s   out;

    // expected results and test names, oldest first
    shiftPkg::shiftOut_s expQ[$];
    string               nameQ[$];

    integer seed = 32'h9e32;
    int errorCount = 0;
    int lateErrors = 0;
    int assertFails = 0;
    int checkCount = 0;
    int testCount = 0;
    int sentCount = 0;

    shiftUnitTop u_shiftUnitTop (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .instr   (instr),
        .opA     (opA),
        .opB     (opB),
        .out     (out)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // one-bit steps, amount times over
    function automatic shiftPkg::shiftOut_s refShift(input shiftPkg::shiftOp_e op,
                                                     input logic [Sb-1:0] amt,
                                                     input logic [W-1:0] a);
        shiftPkg::shiftOut_s r;
        logic [W-1:0] v;
        logic ovf;
        int n;
        v = a;
        ovf = 1'b0;
        n = int'(amt);
        for (int k = 0; k < n; k++) begin
            case (op)
                shiftPkg::opSll: v = {v[W-2:0], 1'b0};
                shiftPkg::opSrl: v = {1'b0, v[W-1:1]};
                shiftPkg::opSra: v = {v[W-1], v[W-1:1]};
                shiftPkg::opSla: begin
                    // bit under the sign falls off on this step
                    if (v[W-2] != a[W-1]) begin
                        ovf = 1'b1;
                    end
                    v = {v[W-1], v[W-3:0], 1'b0};
                end
                default: v = v;
            endcase
        end
        r.valid = 1'b1;
        r.result = v;
        r.zero = (v == '0);
        r.overflow = ovf;
        return r;
    endfunction

    task automatic checkValue(input string name, input shiftPkg::shiftOut_s expected,
                              input shiftPkg::shiftOut_s actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected result %h zero %b ovf %b, got result %h zero %b ovf %b",
                     name, expected.result, expected.zero, expected.overflow,
                     actual.result, actual.zero, actual.overflow);
        end
    endtask

    // compare at the falling edge, outputs settled
    always @(negedge clk) begin
        if (out.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("out.valid went high at %0t ns with no item outstanding", $time);
            end else begin
                checkValue(nameQ.pop_front(), expQ.pop_front(), out);
            end
        end
    end

    task automatic sendItem(input string name, input logic immForm,
                            input shiftPkg::shiftOp_e op, input logic [Sb-1:0] shamt,
                            input logic [W-1:0] a, input logic [W-1:0] b);
        shiftPkg::shiftInstr_u word;
        logic [Sb-1:0] amount;
        // random filler in the bits neither view decodes
        word = $random(seed);
        word.immView.immSel = immForm;
        word.immView.op = op;
        word.immView.shamtImm = shamt;
        // register form amount wraps modulo the operand width
        amount = immForm ? shamt : Sb'(b % W);
        @(posedge clk);
        inValid <= 1'b1;
        instr <= word;
        opA <= a;
        opB <= b;
        expQ.push_back(refShift(op, amount, a));
        nameQ.push_back(name);
        sentCount++;
    endtask

    task automatic finishTest(input string name, input int errStart, input int sentStart);
        @(posedge clk);
        inValid <= 1'b0;
        // tail of the stream, bounded
        for (int i = 0; i < Latency + 4 && expQ.size() != 0; i++) begin
            @(negedge clk);
        end
        testCount++;
        $display("test %s: %0d items, %0d errors", name, sentCount - sentStart,
                 errorCount - errStart);
    endtask

    task automatic logicalTest();
        logic [W-1:0] pats[2];
        int amts[4];
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        // top and bottom bits set in both
        pats = '{32'h8000_0001, 32'hC3A5_5A3D};
        amts = '{0, 1, 15, 31};
        foreach (pats[p]) begin
            foreach (amts[k]) begin
                sendItem("logical", 1'b0, shiftPkg::opSll, '0, pats[p], W'(amts[k]));
                sendItem("logical", 1'b0, shiftPkg::opSrl, '0, pats[p], W'(amts[k]));
            end
        end
        finishTest("logical", errStart, sentStart);
    endtask

    task automatic sraTest();
        logic [W-1:0] vals[3];
        int amts[4];
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        // two negative, one positive
        vals = '{32'h8000_0001, 32'hF0F0_1234, 32'h7FFF_FFFE};
        amts = '{0, 1, 15, 31};
        foreach (vals[p]) begin
            foreach (amts[k]) begin
                sendItem("sra", 1'b0, shiftPkg::opSra, '0, vals[p], W'(amts[k]));
            end
        end
        finishTest("sra", errStart, sentStart);
    endtask

    task automatic slaTest();
        logic [W-1:0] posIn;
        logic [W-1:0] posOut;
        int amts[3];
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        amts = '{1, 4, 31};
        foreach (amts[k]) begin
            // largest value that still fits, and the first one that does not
            posIn = {1'b0, {(W-1){1'b1}}} >> amts[k];
            posOut = W'(1) << (W - 1 - amts[k]);
            sendItem("sla", 1'b0, shiftPkg::opSla, '0, posIn, W'(amts[k]));
            sendItem("sla", 1'b0, shiftPkg::opSla, '0, posOut, W'(amts[k]));
            sendItem("sla", 1'b0, shiftPkg::opSla, '0, ~posIn, W'(amts[k]));
            sendItem("sla", 1'b0, shiftPkg::opSla, '0, ~posOut, W'(amts[k]));
        end
        finishTest("sla", errStart, sentStart);
    endtask

    task automatic unionTest();
        shiftPkg::shiftOp_e ops[4];
        logic [W-1:0] wraps[4];
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        ops = '{shiftPkg::opSll, shiftPkg::opSrl, shiftPkg::opSra, shiftPkg::opSla};
        // low five bits 1, 31, 4 and 0
        wraps = '{32'h0000_0021, 32'h0000_003F, 32'hFFFF_FFE4, 32'h0000_0120};
        // immediate form, opB holds a different amount
        for (int i = 0; i < 4; i++) begin
            sendItem("union", 1'b1, ops[i], Sb'(3 + 7 * i), 32'h8123_4567,
                     W'(28 - 7 * i));
        end
        // register form, shamtImm ignored
        for (int i = 0; i < 4; i++) begin
            sendItem("union", 1'b0, ops[i], Sb'(9), 32'hC001_F00D, wraps[i]);
        end
        finishTest("union", errStart, sentStart);
    endtask

    task automatic randomTest();
        logic [31:0] r;
        logic [W-1:0] a;
        logic [W-1:0] b;
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        for (int i = 0; i < RandomItems; i++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            // zero or one-hot operands, so some shifts reach zero
            case (r[4:3])
                2'd0: a = '0;
                2'd1: a = W'(1) << r[14:10];
                default: a = a;
            endcase
            sendItem("random", r[0], shiftPkg::shiftOp_e'(r[2:1]), r[9:5], a, b);
        end
        finishTest("random", errStart, sentStart);
    endtask

    task automatic resetTest();
        int errStart;
        int sentStart;
        errStart = errorCount;
        sentStart = sentCount;
        for (int i = 0; i < 6; i++) begin
            sendItem("reset", 1'b0, shiftPkg::opSrl, '0, W'(32'hF000_0000 + i), W'(i));
        end
        @(posedge clk);
        arstN <= 1'b0;
        inValid <= 1'b0;
        // items still in the pipe are lost
        expQ.delete();
        nameQ.delete();
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        // out.valid stays low here
        repeat (Latency + 1) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            sendItem("reset", 1'b0, shiftPkg::opSra, '0, W'(32'h8765_4321 + i), W'(4 * i));
        end
        finishTest("reset", errStart, sentStart);
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: run did not finish within %0d cycles", WatchdogCycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        inValid = 1'b0;
        instr = '0;
        opA = '0;
        opB = '0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        logicalTest();
        sraTest();
        slaTest();
        unionTest();
        randomTest();
        resetTest();
        if (expQ.size() != 0) begin
            $display("run ended with %0d expected results never delivered", expQ.size());
            lateErrors = lateErrors + 1;
        end
        assertFails = u_shiftUnitTop.u_shiftUnitProperties.resetFails
                      + u_shiftUnitTop.u_shiftUnitProperties.latencyFails
                      + u_shiftUnitTop.u_shiftUnitProperties.orphanFails;
        $display("%0d tests, %0d results checked, %0d errors, %0d assertion failures",
                 testCount, checkCount, errorCount + lateErrors, assertFails);
        if (errorCount + lateErrors + assertFails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/shiftUnit_properties.sv
`timescale 1ns/100ps
`default_nettype none

`include "shift_config.svh"

// strobe timing checks on the shift unit
module shiftUnitProperties (
    input logic clk,
    input logic arstN,
    input logic inValid,
    input logic outValid
);

    localparam int Latency = `SHIFT_LATENCY;

    // failure counts per property
    int resetFails = 0;
    int latencyFails = 0;
    int orphanFails = 0;

    // nothing leaves while reset is held
    quietInReset: assert property (@(posedge clk) !arstN |-> !outValid)
    else begin
        resetFails++;
        $error("out.valid high while arstN is low");
    end

    // each accepted item comes out after the fixed latency
    fixedLatency: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> ##Latency outValid)
    else begin
        latencyFails++;
        $error("inValid not followed by out.valid after the pipeline latency");
    end

    // no output strobe without a matching input strobe
    noOrphanOut: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid, Latency))
    else begin
        orphanFails++;
        $error("out.valid without an input strobe one latency earlier");
    end

endmodule

bind shiftUnitTop shiftUnitProperties u_shiftUnitProperties (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (out.valid)
);

`default_nettype wire

// File: verilog.f
+incdir+common
common/shiftPkg.sv
shiftUnit/shiftDecode.sv
shiftUnit/barrelShifter.sv
shiftUnit/shiftResult.sv
logic/shiftUnitTop.sv
tests/shiftUnit_properties.sv
tests/shiftUnitTb.sv
